/* modulation.f */
source/modulation_pkg.sv
source/modulation_regs.sv
source/modulation_seq.sv
source/switch_map.sv
source/modulation_top.sv
tests/modulation_tb.sv

/* source/modulation_pkg.sv */
// shared widths, register map, mode and phase codes and structs of the modulation block, imported by each of its modules
`default_nettype none

package modulation_pkg;

  //////////////////////////////////////////////////
  // host register map

  localparam int REG_ADDR_W = 4;
  localparam int REG_DATA_W = 32;

  localparam logic [REG_ADDR_W-1:0] ADDR_CTRL      = 4'd0;
  localparam logic [REG_ADDR_W-1:0] ADDR_PRECHARGE = 4'd1;
  localparam logic [REG_ADDR_W-1:0] ADDR_SAMPLE    = 4'd2;
  // read only, completed az cycles
  localparam logic [REG_ADDR_W-1:0] ADDR_CYCLES    = 4'd3;

  // precharge count, 500us at a 20MHz clock
  localparam int PRECHARGE_W = 24;
  localparam logic [PRECHARGE_W-1:0] PRECHARGE_RESET = 24'd10000;
  localparam logic [REG_DATA_W-1:0]  SAMPLE_RESET    = 32'd200000;

  //////////////////////////////////////////////////
  // modulation mode and sequencer phase

  // code 3 is spare and decodes as no_az
  typedef enum logic [1:0] {
    MODE_NO_AZ        = 2'd0,
    MODE_AZ           = 2'd1,
    MODE_ELECTROMETER = 2'd2
  } mode_t;

  localparam mode_t MODE_RESET = MODE_ELECTROMETER;

  // one full az cycle is settle, sample hi, restore, sample lo
  typedef enum logic [2:0] {
    PH_IDLE      = 3'd0,
    PH_PROTECT   = 3'd1,
    PH_SETTLE    = 3'd2,
    PH_SAMPLE_HI = 3'd3,
    PH_RESTORE   = 3'd4,
    PH_SAMPLE_LO = 3'd5
  } phase_t;

  //////////////////////////////////////////////////
  // switch levels and azmux codes

  localparam logic SW_PC_SIGNAL = 1'b1;
  localparam logic SW_PC_BOOT   = 1'b0;

  // azmux code is enable in bit 3 plus channel number
  localparam logic [3:0] AZMUX_PC_OUT = 4'b1000;
  localparam logic [3:0] AZMUX_BOOT   = 4'b1001;
  localparam logic [3:0] AZMUX_LO     = 4'b1011;

  // host configuration as seen by sequencer and decoder
  typedef struct packed {
    mode_t                   mode;
    logic                    run;
    logic [PRECHARGE_W-1:0]  precharge_n;
    logic [REG_DATA_W-1:0]   sample_n;
  } mod_cfg_t;

  // switch controls leaving the block
  typedef struct packed {
    logic        sw_pc;
    logic [3:0]  azmux;
    logic [7:0]  monitor;
    logic        led0;
  } sw_ctl_t;

endpackage

`default_nettype wire

/* source/modulation_regs.sv */
// host register bank of the modulation block, written by a one-cycle strobe and read back combinationally
`timescale 1ns/10ps
`default_nettype none

module modulation_regs
  import modulation_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   reg_wr,
  input  logic [REG_ADDR_W-1:0]  reg_addr,
  input  logic [REG_DATA_W-1:0]  reg_wdata,
  input  logic                   cycle_done,
  output mod_cfg_t               cfg,
  output logic [REG_DATA_W-1:0]  reg_rdata
);

  // completed az cycles since the last start
  logic [REG_DATA_W-1:0] cycle_count;
  // write to ctrl with the run bit set
  logic                  ctrl_start;

  assign ctrl_start = reg_wr && (reg_addr == ADDR_CTRL) && reg_wdata[4];

  //////////////////////////////////////////////////
  // writable registers

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      cfg.mode        <= MODE_RESET;
      cfg.run         <= 1'b0;
      cfg.precharge_n <= PRECHARGE_RESET;
      cfg.sample_n    <= SAMPLE_RESET;
    end
    else if (reg_wr)
    begin
      case (reg_addr)
        ADDR_CTRL:
        begin
          // mode in bits 1..0, run in bit 4
          cfg.mode <= mode_t'(reg_wdata[1:0]);
          cfg.run  <= reg_wdata[4];
        end
        ADDR_PRECHARGE:
          cfg.precharge_n <= reg_wdata[PRECHARGE_W-1:0];
        ADDR_SAMPLE:
          cfg.sample_n <= reg_wdata;
        // cycles register and unknown addresses drop the write
        default:
          ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // cycle counter

  // free running wrap, restarts from 0 on each run start
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      cycle_count <= '0;
    else if (ctrl_start)
      cycle_count <= '0;
    else if (cycle_done)
      cycle_count <= cycle_count + 1'b1;
  end

  // readback, every field zero extended
  always_comb
  begin
    reg_rdata = '0;
    case (reg_addr)
      ADDR_CTRL:
      begin
        reg_rdata[1:0] = cfg.mode;
        reg_rdata[4]   = cfg.run;
      end
      ADDR_PRECHARGE:
        reg_rdata[PRECHARGE_W-1:0] = cfg.precharge_n;
      ADDR_SAMPLE:
        reg_rdata = cfg.sample_n;
      ADDR_CYCLES:
        reg_rdata = cycle_count;
      default:
        reg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/modulation_seq.sv */
// auto-zero phase sequencer, steps through the az cycle and strobes the end of each sample window
`timescale 1ns/10ps
`default_nettype none

module modulation_seq
  import modulation_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  mod_cfg_t  cfg,
  output phase_t    phase,
  output logic      sample_done,
  output logic      sample_hi,
  output logic      cycle_done
);

  // cycles left in the current phase, 1 on its last cycle
  logic [REG_DATA_W-1:0] count;
  logic                  last_cycle;
  phase_t                phase_next;

  // length of a phase on entry
  // precharge count for protect, settle and restore
  // sample count for both sample windows
  // a programmed 0 still gives one cycle
  function automatic logic [REG_DATA_W-1:0] entry_len(input phase_t ph, input mod_cfg_t c);
    logic [REG_DATA_W-1:0] len;
    if (ph == PH_SAMPLE_HI || ph == PH_SAMPLE_LO)
      len = c.sample_n;
    else
      len = {{(REG_DATA_W-PRECHARGE_W){1'b0}}, c.precharge_n};
    if (len == '0)
      len = 1;
    return len;
  endfunction

  assign last_cycle = (count == 1);

  //////////////////////////////////////////////////
  // next phase

  always_comb
  begin
    phase_next = phase;
    case (phase)
      // leave idle as soon as the host sets run
      PH_IDLE:
        if (cfg.run)
          phase_next = PH_PROTECT;
      // pc switch to boot to shield the signal from az charge injection
      PH_PROTECT:
        if (last_cycle)
          phase_next = PH_SETTLE;
      // azmux over to pc out while signal is still protected
      PH_SETTLE:
        if (last_cycle)
          phase_next = PH_SAMPLE_HI;
      // pc switch to signal, hi window
      PH_SAMPLE_HI:
        if (last_cycle)
          phase_next = PH_RESTORE;
      // back to boot before azmux moves to lo
      PH_RESTORE:
        if (last_cycle)
          phase_next = PH_SAMPLE_LO;
      // lo window closes the cycle
      // run is checked only here so a stop never cuts a cycle short
      PH_SAMPLE_LO:
        if (last_cycle)
          phase_next = cfg.run ? PH_SETTLE : PH_IDLE;
      default:
        phase_next = PH_IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // phase state and countdown

  // entry load is folded into the transition, so no dead cycles between phases
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      phase <= PH_IDLE;
      count <= '0;
    end
    else
    begin
      phase <= phase_next;
      if (phase_next != phase)
        count <= entry_len(phase_next, cfg);
      else if (phase != PH_IDLE)
        count <= count - 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // sample-end strobes

  // last cycle of either sample window
  assign sample_done = last_cycle && (phase == PH_SAMPLE_HI || phase == PH_SAMPLE_LO);

  // window type, valid alongside sample_done
  assign sample_hi = (phase == PH_SAMPLE_HI);

  // end of lo window marks one completed az cycle
  assign cycle_done = last_cycle && (phase == PH_SAMPLE_LO);

endmodule

`default_nettype wire

/* source/modulation_top.sv */
// top level of the modulation block, joins register bank, phase sequencer and switch decoder
`timescale 1ns/10ps
`default_nettype none

module modulation_top
  import modulation_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  // host register port
  input  logic                   reg_wr,
  input  logic [REG_ADDR_W-1:0]  reg_addr,
  input  logic [REG_DATA_W-1:0]  reg_wdata,
  output logic [REG_DATA_W-1:0]  reg_rdata,
  // analog switch controls
  output logic                   sw_pc_ctl,
  output logic [3:0]             azmux,
  output logic [7:0]             monitor,
  output logic                   led0,
  // sample window strobes
  output logic                   sample_done,
  output logic                   sample_hi
);

  mod_cfg_t  cfg;
  phase_t    phase;
  logic      cycle_done;
  sw_ctl_t   sw;

  modulation_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .reg_wr     (reg_wr),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .cycle_done (cycle_done),
    .cfg        (cfg),
    .reg_rdata  (reg_rdata)
  );

  modulation_seq u_seq (
    .clk         (clk),
    .reset       (reset),
    .cfg         (cfg),
    .phase       (phase),
    .sample_done (sample_done),
    .sample_hi   (sample_hi),
    .cycle_done  (cycle_done)
  );

  switch_map u_map (
    .clk   (clk),
    .reset (reset),
    .cfg   (cfg),
    .phase (phase),
    .sw    (sw)
  );

  // switch struct out to the pins
  assign sw_pc_ctl = sw.sw_pc;
  assign azmux     = sw.azmux;
  assign monitor   = sw.monitor;
  assign led0      = sw.led0;

endmodule

`default_nettype wire

/* source/switch_map.sv */
// registered switch decoder, maps mode and sequencer phase onto precharge switch, azmux, monitor and led
`timescale 1ns/10ps
`default_nettype none

module switch_map
  import modulation_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  mod_cfg_t  cfg,
  input  phase_t    phase,
  output sw_ctl_t   sw
);

  // mode with the spare code folded onto no_az
  mode_t    mode_eff;
  sw_ctl_t  sw_next;

  assign mode_eff = (cfg.mode == MODE_AZ || cfg.mode == MODE_ELECTROMETER) ?
                    cfg.mode : MODE_NO_AZ;

  //////////////////////////////////////////////////
  // decode table

  always_comb
  begin
    // one hot phase on the monitor bus, idle shows nothing
    sw_next.monitor = (phase == PH_IDLE) ? 8'b0 : (8'b1 << phase);
    // led marks the hi window in every mode
    sw_next.led0    = (phase == PH_SAMPLE_HI);

    case (mode_eff)
      // hi via pc out, lo via azmux s4
      MODE_AZ:
      begin
        sw_next.sw_pc = (phase == PH_SAMPLE_HI) ? SW_PC_SIGNAL : SW_PC_BOOT;
        if (phase == PH_IDLE || phase == PH_PROTECT || phase == PH_SAMPLE_LO)
          sw_next.azmux = AZMUX_LO;
        else
          sw_next.azmux = AZMUX_PC_OUT;
      end
      // input blocked, azmux sits on boot
      MODE_ELECTROMETER:
      begin
        sw_next.sw_pc = SW_PC_BOOT;
        sw_next.azmux = AZMUX_BOOT;
      end
      // no_az, hi input straight through
      default:
      begin
        sw_next.sw_pc = SW_PC_SIGNAL;
        sw_next.azmux = AZMUX_PC_OUT;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // output register

  // reset state is the idle electrometer decode
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      sw <= '{sw_pc: SW_PC_BOOT, azmux: AZMUX_BOOT, monitor: 8'b0, led0: 1'b0};
    else
      sw <= sw_next;
  end

endmodule

`default_nettype wire

/* tests/modulation_tb.sv */
// directed testbench for the modulation block that runs as top module around modulation_top
`timescale 1ns/10ps
`default_nettype none

module modulation_tb
  import modulation_pkg::*;
();

  logic                   clk;
  logic                   reset;
  logic                   reg_wr;
  logic [REG_ADDR_W-1:0]  reg_addr;
  logic [REG_DATA_W-1:0]  reg_wdata;
  logic [REG_DATA_W-1:0]  reg_rdata;
  logic                   sw_pc_ctl;
  logic [3:0]             azmux;
  logic [7:0]             monitor;
  logic                   led0;
  logic                   sample_done;
  logic                   sample_hi;

  int          errors;
  int          checks;
  int          tests_run;
  // upper bound on cycles for any single wait
  int          wait_limit;
  logic [31:0] rng;

  modulation_top u_modulation_top (
    .clk         (clk),
    .reset       (reset),
    .reg_wr      (reg_wr),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_rdata   (reg_rdata),
    .sw_pc_ctl   (sw_pc_ctl),
    .azmux       (azmux),
    .monitor     (monitor),
    .led0        (led0),
    .sample_done (sample_done),
    .sample_hi   (sample_hi)
  );

  // 40 ns clock
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference rules

  // 32-bit xorshift for random phase lengths
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // decode table where spare mode code 3 behaves as no_az
  function automatic sw_ctl_t ref_switch(input logic [1:0] mode, input logic [2:0] ph);
    sw_ctl_t s;
    s.monitor = (ph == 3'd0) ? 8'h00 : (8'h01 << ph);
    s.led0    = (ph == 3'd3);
    case (mode)
      2'd1:
      begin
        s.sw_pc = (ph == 3'd3);
        // lo input in idle, protect and lo window
        s.azmux = (ph == 3'd0 || ph == 3'd1 || ph == 3'd5) ? AZMUX_LO : AZMUX_PC_OUT;
      end
      2'd2:
      begin
        s.sw_pc = SW_PC_BOOT;
        s.azmux = AZMUX_BOOT;
      end
      default:
      begin
        s.sw_pc = SW_PC_SIGNAL;
        s.azmux = AZMUX_PC_OUT;
      end
    endcase
    return s;
  endfunction

  // phase code recovered from the one-hot monitor bus
  // 7 when the bus shows no legal phase
  function automatic logic [2:0] phase_of(input logic [7:0] mon);
    logic [2:0] ph;
    ph = 3'd7;
    if (mon == 8'h00)
      ph = 3'd0;
    for (int k = 1; k < 6; k++)
      if (mon == (8'h01 << k))
        ph = k[2:0];
    return ph;
  endfunction

  // successor phase in the az cycle where a lo window runs on into settle
  function automatic logic [2:0] phase_after(input logic [2:0] ph);
    logic [2:0] nx;
    nx = ph + 3'd1;
    if (ph == 3'd5)
      nx = 3'd2;
    return nx;
  endfunction

  //////////////////////////////////////////////////
  // bus tasks and checker

  task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset  <= 1'b1;
    reg_wr <= 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  endtask

  // one-cycle strobe that lands on the second edge
  task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    reg_wr    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_wr <= 1'b0;
  endtask

  task automatic read_check(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] expected,
                            input string name);
    @(posedge clk);
    reg_addr <= addr;
    @(negedge clk);
    check(name, reg_rdata, expected);
  endtask

  // gap counts cycles from the call up to and including the strobe cycle
  task automatic wait_sample(output logic hi, output int gap);
    int n;
    n   = 0;
    hi  = 1'b0;
    gap = -1;
    while (gap < 0 && n < wait_limit)
    begin
      @(negedge clk);
      n++;
      if (sample_done)
      begin
        hi  = sample_hi;
        gap = n;
      end
    end
    if (gap < 0)
    begin
      errors++;
      $display("timeout at %0t: no sample_done within %0d cycles", $time, wait_limit);
    end
  endtask

  task automatic wait_led();
    int n;
    n = 0;
    while (!led0 && n < wait_limit)
    begin
      @(negedge clk);
      n++;
    end
    if (!led0)
    begin
      errors++;
      $display("timeout at %0t: the hi window never showed on led0", $time);
    end
  endtask

  task automatic report_test(input string name, input int e0);
    tests_run++;
    $display("test %-16s %0d errors", name, errors - e0);
  endtask

  //////////////////////////////////////////////////
  // directed tests

  task automatic reset_and_readback();
    int e0;
    int a;
    e0 = errors;
    apply_reset();
    read_check(ADDR_CTRL, 32'h2, "ctrl after reset");
    read_check(ADDR_PRECHARGE, 32'd10000, "precharge after reset");
    read_check(ADDR_SAMPLE, 32'd200000, "sample after reset");
    read_check(ADDR_CYCLES, 32'd0, "cycles after reset");
    // idle electrometer decode
    check("sw_pc_ctl", sw_pc_ctl, SW_PC_BOOT);
    check("azmux", azmux, AZMUX_BOOT);
    check("monitor", monitor, 8'h00);
    check("led0", led0, 1'b0);
    check("sample_done", sample_done, 1'b0);
    // upper bits dropped and run stays 0
    write_reg(ADDR_CTRL, 32'hFFFF_FFE1);
    read_check(ADDR_CTRL, 32'h1, "ctrl readback");
    write_reg(ADDR_PRECHARGE, 32'hAB12_3456);
    read_check(ADDR_PRECHARGE, 32'h0012_3456, "precharge readback");
    write_reg(ADDR_SAMPLE, 32'hDEAD_BEEF);
    read_check(ADDR_SAMPLE, 32'hDEAD_BEEF, "sample readback");
    write_reg(ADDR_CYCLES, 32'h55);
    read_check(ADDR_CYCLES, 32'd0, "cycles after write");
    write_reg(4'h9, 32'h1234);
    // registers untouched by the read-only and unknown writes
    read_check(ADDR_CTRL, 32'h1, "ctrl after ignored writes");
    read_check(ADDR_PRECHARGE, 32'h0012_3456, "precharge after ignored writes");
    read_check(ADDR_SAMPLE, 32'hDEAD_BEEF, "sample after ignored writes");
    for (a = 4; a < 16; a++)
      read_check(a[3:0], 32'd0, "unknown address");
    report_test("reset_readback", e0);
  endtask

  task automatic phase_timing();
    int   e0;
    int   trial;
    int   i;
    int   p;
    int   s;
    int   gap;
    logic hi;
    e0 = errors;
    for (trial = 0; trial < 2; trial++)
    begin
      apply_reset();
      p = 0;
      s = 0;
      if (trial == 0)
      begin
        rng = xorshift(rng);
        p   = rng % 20 + 1;
        rng = xorshift(rng);
        s   = rng % 20 + 1;
      end
      write_reg(ADDR_PRECHARGE, p);
      write_reg(ADDR_SAMPLE, s);
      // zero lengths run as one cycle
      p = (p == 0) ? 1 : p;
      s = (s == 0) ? 1 : s;
      write_reg(ADDR_CTRL, 32'h11);
      for (i = 0; i < 6; i++)
      begin
        wait_sample(hi, gap);
        check("sample_hi", hi, (i % 2 == 0));
        // first window also spans the idle cycle, protect and settle
        check("sample gap", gap, (i == 0) ? 2 * p + s + 1 : p + s);
      end
    end
    report_test("phase_timing", e0);
  endtask

  task automatic decode_per_mode();
    int         e0;
    int         m;
    int         n;
    logic [2:0] ph;
    logic [2:0] prev;
    logic [7:0] seen;
    e0 = errors;
    for (m = 0; m < 4; m++)
    begin
      apply_reset();
      write_reg(ADDR_PRECHARGE, 32'd2);
      write_reg(ADDR_SAMPLE, 32'd3);
      write_reg(ADDR_CTRL, 32'h10 | m);
      // the first edge after the write still decodes the old mode
      @(posedge clk);
      seen = 8'h00;
      prev = 3'd0;
      for (n = 0; n < 30; n++)
      begin
        @(negedge clk);
        ph = phase_of(monitor);
        if (ph == 3'd7)
        begin
          errors++;
          $display("monitor at %0t shows no legal phase: %b", $time, monitor);
        end
        else
        begin
          if (ph != prev && ph != phase_after(prev))
          begin
            errors++;
            $display("monitor at %0t jumped from phase %0d to phase %0d", $time, prev, ph);
          end
          check($sformatf("switches mode %0d", m), {sw_pc_ctl, azmux, monitor, led0},
                ref_switch(m[1:0], ph));
          prev = ph;
        end
        seen = seen | monitor;
      end
      check("phases seen on monitor", seen, 8'b0011_1110);
    end
    report_test("decode_per_mode", e0);
  endtask

  task automatic cycles_and_stop();
    int   e0;
    int   i;
    int   n;
    int   los;
    int   gap;
    logic hi;
    logic lo_seen;
    logic stray;
    e0 = errors;
    apply_reset();
    write_reg(ADDR_PRECHARGE, 32'd1);
    write_reg(ADDR_SAMPLE, 32'd2);
    write_reg(ADDR_CTRL, 32'h11);
    los = 0;
    for (i = 0; i < 8 && los < 3; i++)
    begin
      wait_sample(hi, gap);
      if (gap > 0 && !hi)
        los++;
    end
    read_check(ADDR_CYCLES, 32'd3, "cycles after three lo windows");
    // stop with az mode kept
    write_reg(ADDR_CTRL, 32'h01);
    lo_seen = 1'b0;
    for (i = 0; i < 3 && !lo_seen; i++)
    begin
      wait_sample(hi, gap);
      lo_seen = (gap > 0 && !hi);
    end
    if (!lo_seen)
    begin
      errors++;
      $display("the running cycle did not end with its lo window after run was cleared");
    end
    read_check(ADDR_CYCLES, 32'd4, "cycles after stop");
    stray = 1'b0;
    for (n = 0; n < 40; n++)
    begin
      @(negedge clk);
      stray = stray | sample_done;
    end
    if (stray)
    begin
      errors++;
      $display("sample_done pulsed at %0t after the sequencer should have stopped", $time);
    end
    check("monitor after stop", monitor, 8'h00);
    // a new start clears the count
    write_reg(ADDR_CTRL, 32'h11);
    read_check(ADDR_CYCLES, 32'd0, "cycles after restart");
    report_test("cycles_and_stop", e0);
  endtask

  task automatic length_change();
    int   e0;
    int   gap;
    int   g1;
    int   g2;
    int   g3;
    logic hi;
    logic h1;
    logic h2;
    logic h3;
    e0 = errors;
    apply_reset();
    write_reg(ADDR_PRECHARGE, 32'd3);
    write_reg(ADDR_SAMPLE, 32'd6);
    write_reg(ADDR_CTRL, 32'h11);
    wait_sample(hi, gap);
    wait_sample(hi, gap);
    check("sample_hi before change", hi, 1'b0);
    // new length written while the hi window runs
    fork
      begin
        wait_led();
        write_reg(ADDR_SAMPLE, 32'd2);
      end
      begin
        wait_sample(h1, g1);
        wait_sample(h2, g2);
        wait_sample(h3, g3);
      end
    join
    check("sample_hi", h1, 1'b1);
    check("hi gap old length", g1, 3 + 6);
    check("sample_hi", h2, 1'b0);
    check("lo gap new length", g2, 3 + 2);
    check("sample_hi", h3, 1'b1);
    check("hi gap new length", g3, 3 + 2);
    read_check(ADDR_SAMPLE, 32'd2, "sample after change");
    report_test("length_change", e0);
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial
  begin
    reset      = 1'b1;
    reg_wr     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    errors     = 0;
    checks     = 0;
    tests_run  = 0;
    wait_limit = 2000;
    rng        = 32'd51;
    reset_and_readback();
    phase_timing();
    decode_per_mode();
    cycles_and_stop();
    length_change();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
